// ==== source/regfile_pkg.sv ====
package regfile_pkg;

    // ----------------------------------------
    // Register addresses
    // ----------------------------------------
    localparam logic [7:0] ADDR_CHIP_CONFIG    = 8'd0;
    localparam logic [7:0] ADDR_FAST_CLK       = 8'd1;
    localparam logic [7:0] ADDR_PATGEN_RESET   = 8'd2;
    localparam logic [7:0] ADDR_PATGEN_SUSPEND = 8'd3;
    localparam logic [7:0] ADDR_PATGEN_STROBE  = 8'd4;
    localparam logic [7:0] ADDR_PATGEN_CONFIG  = 8'd5;
    localparam logic [7:0] ADDR_PATGEN_ADDR    = 8'd6;
    localparam logic [7:0] ADDR_PATGEN_DATA    = 8'd7;
    localparam logic [7:0] ADDR_TEST_COUNTER   = 8'd8;
    localparam logic [7:0] ADDR_RO_CONTROL     = 8'd9;
    localparam logic [7:0] ADDR_RO_STATUS      = 8'd10;
    localparam logic [7:0] ADDR_RO_FIFO        = 8'd11;
    localparam logic [7:0] ADDR_TRIG_DELAY     = 8'd13;
    localparam logic [7:0] ADDR_TRIG_WINDOW    = 8'd14;
    localparam logic [7:0] ADDR_DESER_DELAY    = 8'd15;
    localparam logic [7:0] ADDR_CHIP_LDS       = 8'd16;
    localparam logic [7:0] ADDR_CHIP_RAMWR     = 8'd17;
    localparam logic [7:0] ADDR_CONFIG_MODE    = 8'd19;
    localparam logic [7:0] ADDR_WORK_MODE      = 8'd20;
    localparam logic [7:0] ADDR_ETH_IP         = 8'd30;
    localparam logic [7:0] ADDR_ETH_PORT       = 8'd31;
    localparam logic [7:0] ADDR_ETH_MAC        = 8'd32;
    localparam logic [7:0] ADDR_ETH_CONFIG     = 8'd33;
    localparam logic [7:0] ADDR_ETH_DELAY      = 8'd34;
    localparam logic [7:0] ADDR_ETH_TIMEOUT    = 8'd35;
    localparam logic [7:0] ADDR_ETH_SUBNET     = 8'd36;
    localparam logic [7:0] ADDR_TRIG_CONFIG    = 8'd40;
    localparam logic [7:0] ADDR_TRIG_DELAY24   = 8'd41;
    localparam logic [7:0] ADDR_TRIG_DURATION  = 8'd42;
    localparam logic [7:0] ADDR_TRIG_CONFIG2   = 8'd43;
    localparam logic [7:0] ADDR_TRIGGEN_NUM    = 8'd44;
    localparam logic [7:0] ADDR_TRIGGEN_LENGTH = 8'd45;
    localparam logic [7:0] ADDR_TRIGGEN_DIST   = 8'd46;
    localparam logic [7:0] ADDR_TRIGGEN_INIT   = 8'd47;
    localparam logic [7:0] ADDR_TEST_PATTERN   = 8'd80;

    // ----------------------------------------
    // Reset values and fixed bytes
    // ----------------------------------------
    localparam logic [7:0]  RST_PATGEN_RESET   = 8'h01;
    localparam logic [7:0]  RST_RO_CONTROL     = 8'h80;
    localparam logic [7:0]  RST_DESER_DELAY    = 8'h01;
    localparam logic [7:0]  RST_TRIG_CONFIG    = 8'h10;
    localparam logic [7:0]  RST_TRIGGEN_LENGTH = 8'h0F;
    localparam logic [7:0]  RST_COUNTER        = 8'h11;
    localparam logic [7:0]  TEST_PATTERN       = 8'hAB;
    localparam logic [31:0] RST_ETH_IP         = 32'hC0A8_0180;
    localparam logic [31:0] RST_ETH_SUBNET     = 32'hFFFF_FF00;
    localparam logic [15:0] RST_ETH_PORT       = 16'h04D2;
    localparam logic [47:0] RST_ETH_MAC        = 48'h0200_0000_0000;
    localparam logic [15:0] RST_ETH_DELAY      = 16'h000A;
    localparam logic [23:0] RST_ETH_TIMEOUT    = 24'hFF_FFFF;
    localparam logic [15:0] RST_TRIGGEN_NUM    = 16'h0001;
    // Returned for every byte of a data set that started on an empty FIFO
    localparam logic [7:0]  EMPTY_FILL         = 8'hFF;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] wdata;
    } reg_bus_t;

    typedef struct packed {
        logic [7:0] chip_config;
        logic [7:0] fast_clk;
        logic [7:0] patgen_reset;
        logic [7:0] patgen_suspend;
        logic [7:0] patgen_strobe;
        logic [7:0] patgen_config;
        logic [7:0] patgen_addr;
        logic [7:0] patgen_data;
        logic [7:0] ro_control;
        logic [7:0] trig_delay;
        logic [7:0] trig_window;
        logic [7:0] deser_delay;
        logic [7:0] chip_lds;
        logic [7:0] chip_ramwr;
        logic [7:0] config_mode;
        logic [7:0] work_mode;
        logic [7:0] trig_config;
        logic [7:0] trig_config2;
        logic [7:0] triggen_length;
        logic [7:0] eth_config;
    } ctrl_out_t;

    typedef struct packed {
        logic [47:0] eth_mac;
        logic [31:0] eth_ip;
        logic [31:0] eth_subnet;
        logic [15:0] eth_port;
        logic [15:0] eth_delay;
        logic [23:0] eth_timeout;
        logic [23:0] trig_delay;
        logic [23:0] trig_duration;
        logic [15:0] triggen_num;
        logic [15:0] triggen_dist;
        logic [15:0] triggen_init;
    } wide_out_t;

    // Field order gives the status byte layout, bit 0 is empty
    typedef struct packed {
        logic full;
        logic prog_full;
        logic empty;
    } ro_status_t;

endpackage

// ==== source/ctrl_regs.sv ====
module ctrl_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  regfile_pkg::reg_bus_t  bus,
    output regfile_pkg::ctrl_out_t ctrl,
    output logic [7:0]             rdata,
    output logic                   hit
);

    logic [7:0] test_counter;

    // ----------------------------------------
    // Writes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl                <= '0;
            ctrl.patgen_reset   <= regfile_pkg::RST_PATGEN_RESET;
            ctrl.ro_control     <= regfile_pkg::RST_RO_CONTROL;
            ctrl.deser_delay    <= regfile_pkg::RST_DESER_DELAY;
            ctrl.trig_config    <= regfile_pkg::RST_TRIG_CONFIG;
            ctrl.triggen_length <= regfile_pkg::RST_TRIGGEN_LENGTH;
        end else if (bus.wr) begin
            case (bus.addr)
                regfile_pkg::ADDR_CHIP_CONFIG:    ctrl.chip_config    <= bus.wdata;
                regfile_pkg::ADDR_FAST_CLK:       ctrl.fast_clk       <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_RESET:   ctrl.patgen_reset   <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_SUSPEND: ctrl.patgen_suspend <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_STROBE:  ctrl.patgen_strobe  <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_CONFIG:  ctrl.patgen_config  <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_ADDR:    ctrl.patgen_addr    <= bus.wdata;
                regfile_pkg::ADDR_PATGEN_DATA:    ctrl.patgen_data    <= bus.wdata;
                regfile_pkg::ADDR_RO_CONTROL:     ctrl.ro_control     <= bus.wdata;
                regfile_pkg::ADDR_TRIG_DELAY:     ctrl.trig_delay     <= bus.wdata;
                regfile_pkg::ADDR_TRIG_WINDOW:    ctrl.trig_window    <= bus.wdata;
                regfile_pkg::ADDR_DESER_DELAY:    ctrl.deser_delay    <= bus.wdata;
                regfile_pkg::ADDR_CHIP_LDS:       ctrl.chip_lds       <= bus.wdata;
                regfile_pkg::ADDR_CHIP_RAMWR:     ctrl.chip_ramwr     <= bus.wdata;
                regfile_pkg::ADDR_CONFIG_MODE:    ctrl.config_mode    <= bus.wdata;
                regfile_pkg::ADDR_WORK_MODE:      ctrl.work_mode      <= bus.wdata;
                regfile_pkg::ADDR_TRIG_CONFIG:    ctrl.trig_config    <= bus.wdata;
                regfile_pkg::ADDR_TRIG_CONFIG2:   ctrl.trig_config2   <= bus.wdata;
                regfile_pkg::ADDR_TRIGGEN_LENGTH: ctrl.triggen_length <= bus.wdata;
                regfile_pkg::ADDR_ETH_CONFIG:     ctrl.eth_config     <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Readout test counter, steps once per read of its address
    always_ff @(posedge clk) begin
        if (rst) begin
            test_counter <= regfile_pkg::RST_COUNTER;
        end else if (bus.rd && bus.addr == regfile_pkg::ADDR_TEST_COUNTER) begin
            test_counter <= test_counter + 8'd1;
        end
    end

    // ----------------------------------------
    // Read decode
    // ----------------------------------------
    always_comb begin
        hit = 1'b1;
        case (bus.addr)
            regfile_pkg::ADDR_CHIP_CONFIG:    rdata = ctrl.chip_config;
            regfile_pkg::ADDR_FAST_CLK:       rdata = ctrl.fast_clk;
            regfile_pkg::ADDR_PATGEN_RESET:   rdata = ctrl.patgen_reset;
            regfile_pkg::ADDR_PATGEN_SUSPEND: rdata = ctrl.patgen_suspend;
            regfile_pkg::ADDR_PATGEN_STROBE:  rdata = ctrl.patgen_strobe;
            regfile_pkg::ADDR_PATGEN_CONFIG:  rdata = ctrl.patgen_config;
            regfile_pkg::ADDR_PATGEN_ADDR:    rdata = ctrl.patgen_addr;
            regfile_pkg::ADDR_PATGEN_DATA:    rdata = ctrl.patgen_data;
            regfile_pkg::ADDR_TEST_COUNTER:   rdata = test_counter;
            regfile_pkg::ADDR_RO_CONTROL:     rdata = ctrl.ro_control;
            regfile_pkg::ADDR_TRIG_DELAY:     rdata = ctrl.trig_delay;
            regfile_pkg::ADDR_TRIG_WINDOW:    rdata = ctrl.trig_window;
            regfile_pkg::ADDR_DESER_DELAY:    rdata = ctrl.deser_delay;
            regfile_pkg::ADDR_CHIP_LDS:       rdata = ctrl.chip_lds;
            regfile_pkg::ADDR_CHIP_RAMWR:     rdata = ctrl.chip_ramwr;
            regfile_pkg::ADDR_CONFIG_MODE:    rdata = ctrl.config_mode;
            regfile_pkg::ADDR_WORK_MODE:      rdata = ctrl.work_mode;
            regfile_pkg::ADDR_TRIG_CONFIG:    rdata = ctrl.trig_config;
            regfile_pkg::ADDR_TRIG_CONFIG2:   rdata = ctrl.trig_config2;
            regfile_pkg::ADDR_TRIGGEN_LENGTH: rdata = ctrl.triggen_length;
            regfile_pkg::ADDR_ETH_CONFIG:     rdata = ctrl.eth_config;
            regfile_pkg::ADDR_TEST_PATTERN:   rdata = regfile_pkg::TEST_PATTERN;
            default: begin
                rdata = 8'h00;
                hit   = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/wide_regs.sv ====
module wide_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  regfile_pkg::reg_bus_t  bus,
    output regfile_pkg::wide_out_t wide,
    output logic [7:0]             rdata,
    output logic                   hit
);

    localparam int NUM_REGS = 11;

    // Per register tables, listed in wide_out_t order
    localparam int REG_BYTES [NUM_REGS] = '{6, 4, 4, 2, 2, 3, 3, 3, 2, 2, 2};

    localparam logic [7:0] REG_ADDR [NUM_REGS] = '{
        regfile_pkg::ADDR_ETH_MAC,
        regfile_pkg::ADDR_ETH_IP,
        regfile_pkg::ADDR_ETH_SUBNET,
        regfile_pkg::ADDR_ETH_PORT,
        regfile_pkg::ADDR_ETH_DELAY,
        regfile_pkg::ADDR_ETH_TIMEOUT,
        regfile_pkg::ADDR_TRIG_DELAY24,
        regfile_pkg::ADDR_TRIG_DURATION,
        regfile_pkg::ADDR_TRIGGEN_NUM,
        regfile_pkg::ADDR_TRIGGEN_DIST,
        regfile_pkg::ADDR_TRIGGEN_INIT
    };

    localparam logic [47:0] REG_RST [NUM_REGS] = '{
        regfile_pkg::RST_ETH_MAC,
        48'(regfile_pkg::RST_ETH_IP),
        48'(regfile_pkg::RST_ETH_SUBNET),
        48'(regfile_pkg::RST_ETH_PORT),
        48'(regfile_pkg::RST_ETH_DELAY),
        48'(regfile_pkg::RST_ETH_TIMEOUT),
        48'h0,
        48'h0,
        48'(regfile_pkg::RST_TRIGGEN_NUM),
        48'h0,
        48'h0
    };

    logic [47:0]         value   [NUM_REGS];
    logic [7:0]          rd_byte [NUM_REGS];
    logic [NUM_REGS-1:0] sel;

    // ----------------------------------------
    // One shift register and cursor each
    // ----------------------------------------
    for (genvar g = 0; g < NUM_REGS; g++) begin : g_reg
        // Keeps bytes above the register size at zero
        localparam logic [47:0] MASK = {48{1'b1}} >> (8 * (6 - REG_BYTES[g]));

        logic [47:0] shift_q;
        logic [2:0]  cursor;

        assign sel[g] = bus.addr == REG_ADDR[g];

        always_ff @(posedge clk) begin
            if (rst) begin
                shift_q <= REG_RST[g];
                cursor  <= '0;
            end else begin
                if (bus.wr && sel[g]) begin
                    shift_q <= {shift_q[39:0], bus.wdata} & MASK;
                end
                if (bus.rd && sel[g]) begin
                    if (int'(cursor) == REG_BYTES[g] - 1) begin
                        cursor <= '0;
                    end else begin
                        cursor <= cursor + 3'd1;
                    end
                end
            end
        end

        // Cursor 0 points at the most significant byte
        assign rd_byte[g] = shift_q[8 * (REG_BYTES[g] - 1 - int'(cursor)) +: 8];
        assign value[g]   = shift_q;
    end

    always_comb begin
        rdata = 8'h00;
        hit   = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (sel[i]) begin
                rdata = rd_byte[i];
                hit   = 1'b1;
            end
        end
    end

    assign wide.eth_mac       = value[0];
    assign wide.eth_ip        = value[1][31:0];
    assign wide.eth_subnet    = value[2][31:0];
    assign wide.eth_port      = value[3][15:0];
    assign wide.eth_delay     = value[4][15:0];
    assign wide.eth_timeout   = value[5][23:0];
    assign wide.trig_delay    = value[6][23:0];
    assign wide.trig_duration = value[7][23:0];
    assign wide.triggen_num   = value[8][15:0];
    assign wide.triggen_dist  = value[9][15:0];
    assign wide.triggen_init  = value[10][15:0];

endmodule

// ==== source/readout_fifo.sv ====
module readout_fifo #(
    parameter int FIFO_DEPTH      = 16,
    parameter int PROG_FULL_LEVEL = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  regfile_pkg::reg_bus_t   bus,
    input  logic [63:0]             din,
    input  logic                    wr_en,
    output regfile_pkg::ro_status_t status,
    output logic [7:0]              rdata,
    output logic                    hit
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [63:0]      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic [2:0]       byte_cnt;
    logic             empty_at_start;
    logic             set_valid;
    logic             sel_data;
    logic             sel_status;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // ----------------------------------------
    // Word storage
    // ----------------------------------------
    assign status.full      = count == CNT_W'(FIFO_DEPTH);
    assign status.prog_full = count >= CNT_W'(PROG_FULL_LEVEL);
    assign status.empty     = count == '0;

    // Pushes to a full FIFO are lost
    assign push = wr_en && !status.full;
    assign pop  = bus.rd && sel_data && set_valid && byte_cnt == 3'd7;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // ----------------------------------------
    // Host side data sets
    // ----------------------------------------
    assign sel_data   = bus.addr == regfile_pkg::ADDR_RO_FIFO;
    assign sel_status = bus.addr == regfile_pkg::ADDR_RO_STATUS;

    // First byte looks at the live flag, the rest follow what it saw
    assign set_valid = (byte_cnt == 3'd0) ? !status.empty : !empty_at_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt       <= '0;
            empty_at_start <= 1'b0;
        end else if (bus.rd && sel_data) begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'd0) begin
                empty_at_start <= status.empty;
            end
        end
    end

    always_comb begin
        hit = sel_data || sel_status;
        if (sel_status) begin
            rdata = {5'b0, status};
        end else if (sel_data && set_valid) begin
            // Inverted cursor times 8 selects bytes MSB first
            rdata = mem[rd_ptr][{~byte_cnt, 3'b000} +: 8];
        end else if (sel_data) begin
            rdata = regfile_pkg::EMPTY_FILL;
        end else begin
            rdata = 8'h00;
        end
    end

endmodule

// ==== source/regfile_top.sv ====
module regfile_top #(
    parameter int FIFO_DEPTH      = 16,
    parameter int PROG_FULL_LEVEL = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   read,
    input  logic                   write,
    input  logic [7:0]             address,
    input  logic [7:0]             write_data,
    output logic [7:0]             read_data,
    output logic                   done,
    output regfile_pkg::ctrl_out_t ctrl,
    output regfile_pkg::wide_out_t wide,
    input  logic [63:0]            fifo_din,
    input  logic                   fifo_wr_en,
    output logic                   fifo_full,
    output logic                   fifo_empty,
    output logic                   fifo_prog_full
);

    regfile_pkg::reg_bus_t   bus;
    regfile_pkg::ro_status_t ro_status;
    logic [7:0]              ctrl_rdata;
    logic [7:0]              wide_rdata;
    logic [7:0]              fifo_rdata;
    logic [7:0]              rdata_mux;
    logic                    ctrl_hit;
    logic                    wide_hit;
    logic                    fifo_hit;

    assign bus = '{rd: read, wr: write, addr: address, wdata: write_data};

    ctrl_regs u_ctrl_regs (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus),
        .ctrl  (ctrl),
        .rdata (ctrl_rdata),
        .hit   (ctrl_hit)
    );

    wide_regs u_wide_regs (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus),
        .wide  (wide),
        .rdata (wide_rdata),
        .hit   (wide_hit)
    );

    readout_fifo #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
    ) u_readout_fifo (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .din    (fifo_din),
        .wr_en  (fifo_wr_en),
        .status (ro_status),
        .rdata  (fifo_rdata),
        .hit    (fifo_hit)
    );

    assign fifo_full      = ro_status.full;
    assign fifo_empty     = ro_status.empty;
    assign fifo_prog_full = ro_status.prog_full;

    // Address ranges are disjoint, at most one peer hits
    always_comb begin
        if (ctrl_hit) begin
            rdata_mux = ctrl_rdata;
        end else if (wide_hit) begin
            rdata_mux = wide_rdata;
        end else if (fifo_hit) begin
            rdata_mux = fifo_rdata;
        end else begin
            rdata_mux = 8'h00;
        end
    end

    // Read data and done one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= 8'h00;
            done      <= 1'b0;
        end else begin
            done <= read;
            if (read) begin
                read_data <= rdata_mux;
            end
        end
    end

endmodule

// ==== verif/regfile_tests.svh ====
`ifndef REGFILE_TESTS_SVH
`define REGFILE_TESTS_SVH

// Single-byte control addresses in ctrl_out_t field order
localparam int CTRL_BYTES = 20;
localparam logic [7:0] CTRL_ADDRS [CTRL_BYTES] = '{
    8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7,
    8'd9, 8'd13, 8'd14, 8'd15, 8'd16, 8'd17, 8'd19, 8'd20,
    8'd40, 8'd43, 8'd45, 8'd33
};

// ----------------------------------------
// Bus and FIFO drivers
// ----------------------------------------
task automatic report_mismatch(input string name,
                               input logic [$bits(regfile_pkg::wide_out_t)-1:0] got,
                               input logic [$bits(regfile_pkg::wide_out_t)-1:0] exp);
    $display("mismatch %s got %0h expected %0h", name, got, exp);
    errors++;
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
        tests_failed++;
        $display("%s: fail, %0d errors", name, errors - errors_before);
    end else begin
        $display("%s: pass", name);
    end
endtask

task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
    address    = addr;
    write_data = data;
    write      = 1'b1;
    @(negedge clk);
    write = 1'b0;
endtask

// One strobe edge per call with data sampled on the falling edge after done
task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
    int waited;
    data = 8'h00;
    if (!timed_out) begin
        address = addr;
        read    = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < READ_TIMEOUT);
        read = 1'b0;
        if (done) begin
            data = read_data;
        end else begin
            $display("timeout, done never rose after a read of address %0h", addr);
            errors++;
            timed_out = 1'b1;
        end
    end
endtask

task automatic read_expect(input logic [7:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    bus_read(addr, got);
    if (got !== exp) report_mismatch($sformatf("read_data addr %0h", addr), got, exp);
endtask

task automatic push_word(input logic [63:0] w);
    fifo_din   = w;
    fifo_wr_en = 1'b1;
    @(negedge clk);
    fifo_wr_en = 1'b0;
endtask

// Eight reads of the data address with the MSB first
task automatic read_set_expect(input logic [63:0] exp);
    for (int k = 0; k < 8; k++) begin
        read_expect(regfile_pkg::ADDR_RO_FIFO, exp[8 * (7 - k) +: 8]);
    end
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic reset_values_test();
    int                     e0;
    regfile_pkg::ctrl_out_t ctrl_exp;
    regfile_pkg::wide_out_t wide_exp;
    e0 = errors;
    if (done !== 1'b0) report_mismatch("done", done, 1'b0);
    if (read_data !== 8'h00) report_mismatch("read_data", read_data, 8'h00);
    read_expect(regfile_pkg::ADDR_PATGEN_RESET, 8'h01);
    read_expect(regfile_pkg::ADDR_RO_CONTROL, 8'h80);
    read_expect(regfile_pkg::ADDR_DESER_DELAY, 8'h01);
    read_expect(regfile_pkg::ADDR_TRIG_CONFIG, 8'h10);
    read_expect(regfile_pkg::ADDR_TRIGGEN_LENGTH, 8'h0F);
    read_expect(regfile_pkg::ADDR_TEST_PATTERN, 8'hAB);
    read_expect(8'd12, 8'h00);
    read_expect(8'hC8, 8'h00);

    // Done drops on the first edge without a read
    @(negedge clk);
    if (done !== 1'b0) report_mismatch("done", done, 1'b0);

    ctrl_exp                = '0;
    ctrl_exp.patgen_reset   = 8'h01;
    ctrl_exp.ro_control     = 8'h80;
    ctrl_exp.deser_delay    = 8'h01;
    ctrl_exp.trig_config    = 8'h10;
    ctrl_exp.triggen_length = 8'h0F;
    if (ctrl !== ctrl_exp) report_mismatch("ctrl", ctrl, ctrl_exp);

    wide_exp             = '0;
    wide_exp.eth_mac     = 48'h0200_0000_0000;
    wide_exp.eth_ip      = 32'hC0A8_0180;
    wide_exp.eth_subnet  = 32'hFFFF_FF00;
    wide_exp.eth_port    = 16'h04D2;
    wide_exp.eth_delay   = 16'h000A;
    wide_exp.eth_timeout = 24'hFF_FFFF;
    wide_exp.triggen_num = 16'h0001;
    if (wide !== wide_exp) report_mismatch("wide", wide, wide_exp);
    finish_test("reset_values", e0);
endtask

task automatic ctrl_regs_test();
    int          e0;
    logic [7:0]  written [CTRL_BYTES];
    logic [7:0]  field;
    logic [159:0] ctrl_bits;
    e0 = errors;
    for (int i = 0; i < CTRL_BYTES; i++) begin
        random_byte(written[i]);
        bus_write(CTRL_ADDRS[i], written[i]);
        ctrl_bits = ctrl;
        field = ctrl_bits[8 * (CTRL_BYTES - 1 - i) +: 8];
        if (field !== written[i]) begin
            report_mismatch($sformatf("ctrl byte %0d", i), field, written[i]);
        end
        read_expect(CTRL_ADDRS[i], written[i]);
    end
    // Second pass catches writes that leak into other registers
    for (int i = 0; i < CTRL_BYTES; i++) begin
        read_expect(CTRL_ADDRS[i], written[i]);
    end
    finish_test("ctrl_regs", e0);
endtask

task automatic test_counter_test();
    int         e0;
    logic [7:0] exp;
    e0  = errors;
    exp = 8'h11;
    for (int i = 0; i < 6; i++) begin
        read_expect(regfile_pkg::ADDR_TEST_COUNTER, exp);
        exp = exp + 8'd1;
    end
    finish_test("test_counter", e0);
endtask

task automatic wide_regs_test();
    int         e0;
    int         ip_cursor;
    logic [7:0] ip_bytes [4];
    logic [7:0] trig_bytes [3];
    e0 = errors;
    if (wide.eth_ip !== 32'hC0A80180) report_mismatch("wide.eth_ip", wide.eth_ip, 32'hC0A80180);
    read_expect(regfile_pkg::ADDR_ETH_IP, 8'hC0);
    read_expect(regfile_pkg::ADDR_ETH_IP, 8'hA8);
    read_expect(regfile_pkg::ADDR_ETH_IP, 8'h01);
    read_expect(regfile_pkg::ADDR_ETH_IP, 8'h80);
    read_expect(regfile_pkg::ADDR_ETH_IP, 8'hC0);
    ip_cursor = 1;

    // Trigger delay starts from a fresh cursor at the MSB
    for (int k = 0; k < 3; k++) begin
        random_byte(trig_bytes[k]);
        bus_write(regfile_pkg::ADDR_TRIG_DELAY24, trig_bytes[k]);
    end
    if (wide.trig_delay !== {trig_bytes[0], trig_bytes[1], trig_bytes[2]}) begin
        report_mismatch("wide.trig_delay", wide.trig_delay,
                        {trig_bytes[0], trig_bytes[1], trig_bytes[2]});
    end
    for (int k = 0; k < 3; k++) begin
        read_expect(regfile_pkg::ADDR_TRIG_DELAY24, trig_bytes[k]);
    end

    // Writes leave the IP cursor where the reads put it
    for (int k = 0; k < 4; k++) begin
        random_byte(ip_bytes[k]);
        bus_write(regfile_pkg::ADDR_ETH_IP, ip_bytes[k]);
    end
    if (wide.eth_ip !== {ip_bytes[0], ip_bytes[1], ip_bytes[2], ip_bytes[3]}) begin
        report_mismatch("wide.eth_ip", wide.eth_ip,
                        {ip_bytes[0], ip_bytes[1], ip_bytes[2], ip_bytes[3]});
    end
    for (int k = 0; k < 5; k++) begin
        read_expect(regfile_pkg::ADDR_ETH_IP, ip_bytes[ip_cursor]);
        ip_cursor = (ip_cursor + 1) % 4;
    end
    finish_test("wide_regs", e0);
endtask

task automatic fifo_data_test();
    int          e0;
    logic [63:0] w0;
    logic [63:0] w1;
    e0 = errors;
    read_set_expect({8{8'hFF}});
    random_word(w0);
    random_word(w1);
    push_word(w0);
    push_word(w1);
    if (fifo_empty !== 1'b0) report_mismatch("fifo_empty", fifo_empty, 1'b0);
    read_set_expect(w0);
    read_set_expect(w1);
    if (fifo_empty !== 1'b1) report_mismatch("fifo_empty", fifo_empty, 1'b1);
    finish_test("fifo_data", e0);
endtask

task automatic fifo_status_test();
    int          e0;
    logic [63:0] w;
    logic [63:0] pushed [$];
    e0 = errors;
    read_expect(regfile_pkg::ADDR_RO_STATUS, 8'h01);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
        random_word(w);
        push_word(w);
        pushed.push_back(w);
        if (i == PROG_FULL_LEVEL - 2) begin
            read_expect(regfile_pkg::ADDR_RO_STATUS, 8'h00);
        end
        if (i == PROG_FULL_LEVEL - 1) begin
            read_expect(regfile_pkg::ADDR_RO_STATUS, 8'h02);
            if (fifo_prog_full !== 1'b1) report_mismatch("fifo_prog_full", fifo_prog_full, 1'b1);
        end
    end
    if (fifo_full !== 1'b1) report_mismatch("fifo_full", fifo_full, 1'b1);
    read_expect(regfile_pkg::ADDR_RO_STATUS, 8'h06);

    // This word is lost and never read back
    random_word(w);
    push_word(w);
    while (pushed.size() > 0) begin
        read_set_expect(pushed.pop_front());
    end
    read_set_expect({8{8'hFF}});
    read_expect(regfile_pkg::ADDR_RO_STATUS, 8'h01);
    finish_test("fifo_status", e0);
endtask

`endif

// ==== verif/regfile_tb.sv ====
module regfile_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH      = 8;
    localparam int PROG_FULL_LEVEL = 6;
    localparam int READ_TIMEOUT    = 50;

    logic                   clk;
    logic                   rst;
    logic                   read;
    logic                   write;
    logic [7:0]             address;
    logic [7:0]             write_data;
    logic [7:0]             read_data;
    logic                   done;
    regfile_pkg::ctrl_out_t ctrl;
    regfile_pkg::wide_out_t wide;
    logic [63:0]            fifo_din;
    logic                   fifo_wr_en;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   fifo_prog_full;

    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    regfile_top #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
    ) u_regfile_top (
        .clk            (clk),
        .rst            (rst),
        .read           (read),
        .write          (write),
        .address        (address),
        .write_data     (write_data),
        .read_data      (read_data),
        .done           (done),
        .ctrl           (ctrl),
        .wide           (wide),
        .fifo_din       (fifo_din),
        .fifo_wr_en     (fifo_wr_en),
        .fifo_full      (fifo_full),
        .fifo_empty     (fifo_empty),
        .fifo_prog_full (fifo_prog_full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Random source
    // ----------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic random_byte(output logic [7:0] b);
        logic [7:0] acc;
        acc = 8'h00;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            acc = {acc[6:0], lfsr_state[0]};
        end
        b = acc;
    endtask

    task automatic random_word(output logic [63:0] w);
        logic [7:0] b;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            random_byte(b);
            w = {w[55:0], b};
        end
    endtask

    `include "regfile_tests.svh"

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst          = 1'b1;
        read         = 1'b0;
        write        = 1'b0;
        address      = 8'h00;
        write_data   = 8'h00;
        fifo_din     = 64'h0;
        fifo_wr_en   = 1'b0;
        lfsr_state   = 32'hc7f2;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        if (!timed_out) reset_values_test();
        if (!timed_out) ctrl_regs_test();
        if (!timed_out) test_counter_test();
        if (!timed_out) wide_regs_test();
        if (!timed_out) fifo_data_test();
        if (!timed_out) fifo_status_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verif
source/regfile_pkg.sv
source/ctrl_regs.sv
source/wide_regs.sv
source/readout_fifo.sv
source/regfile_top.sv
verif/regfile_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run the testbench, decide from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module regfile_tb -o regfile_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/regfile_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
exit 1
